/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_lcd
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* lcd_checker.sv */
`timescale 1ns/100ps

module lcd_checker (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 e,
	input logic                 rs,
	input logic [7:0]           lcd_data,
	input logic                 busy,
	input lcd_pkg::ctrl_state_t state
);

	int fails = 0; // failed assertion count

	a_busy_with_e: assert property (@(posedge clk) disable iff (!rst_n) e |-> busy)
		else begin
			fails++;
			$error("e is high while busy is low");
		end

	// bus word must not move under a strobe
	a_stable_in_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		e && $past(e) |-> $stable(lcd_data) && $stable(rs))
		else begin
			fails++;
			$error("lcd_data or rs changed while e was high");
		end

	a_idle_in_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(state == lcd_pkg::st_ready) |-> !e)
		else begin
			fails++;
			$error("e is high in the ready state");
		end

endmodule

/* lcd_controller.sv */
`timescale 1ns/100ps

module lcd_controller #(
	parameter int clk_freq = 35 // clock cycles per microsecond
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [6:0] cfg,
	input  logic       lcd_enable,
	input  logic [9:0] lcd_bus,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	localparam int power_up_cycles = 500 * clk_freq; // power-up wait
	localparam int init_cycles     = 440 * clk_freq; // whole init sequence
	localparam int pulse_cycles    = 10 * clk_freq;  // e width during init
	localparam int dc_start        = 60 * clk_freq;  // display control pulse
	localparam int clr_start       = 120 * clk_freq; // clear pulse
	localparam int em_start        = 330 * clk_freq; // entry mode pulse
	localparam int send_cycles     = 50 * clk_freq;  // last count of a transaction
	localparam int e_on            = clk_freq;       // e rises here in st_send
	localparam int e_off           = 14 * clk_freq;  // and falls here
	localparam int cnt_w           = $clog2(power_up_cycles + 1);

	lcd_pkg::ctrl_state_t state;
	logic [cnt_w-1:0]     cnt;
	logic [cnt_w-1:0]     cnt_next;
	logic [7:0]           fs_word;
	logic [7:0]           dc_word;
	logic [7:0]           em_word;

	assign cnt_next = cnt + 1'b1;

	// init commands with their configuration bits
	assign fs_word = lcd_pkg::cmd_function_set | {4'b0000, cfg[6:5], 2'b00};
	assign dc_word = lcd_pkg::cmd_display_ctrl | {5'b00000, cfg[4:2]};
	assign em_word = lcd_pkg::cmd_entry_mode | {6'b000000, cfg[1:0]};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= lcd_pkg::st_power_up;
			cnt      <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= 8'h00;
			busy     <= 1'b1;
		end else begin
			case (state)
				lcd_pkg::st_power_up: begin
					if (cnt == cnt_w'(power_up_cycles - 1)) begin
						cnt   <= '0;
						state <= lcd_pkg::st_init;
					end else begin
						cnt <= cnt_next;
					end
				end
				lcd_pkg::st_init: begin
					rs <= 1'b0;
					rw <= 1'b0;
					if (cnt == cnt_w'(init_cycles - 1)) begin
						cnt      <= '0;
						e        <= 1'b0;
						lcd_data <= 8'h00;
						busy     <= 1'b0;
						state    <= lcd_pkg::st_ready;
					end else begin
						cnt <= cnt_next;
						// data changes only at a pulse start, held through the gap
						if (cnt < cnt_w'(pulse_cycles)) begin
							e        <= 1'b1;
							lcd_data <= fs_word;
						end else if (cnt < cnt_w'(dc_start)) begin
							e <= 1'b0;
						end else if (cnt < cnt_w'(dc_start + pulse_cycles)) begin
							e        <= 1'b1;
							lcd_data <= dc_word;
						end else if (cnt < cnt_w'(clr_start)) begin
							e <= 1'b0;
						end else if (cnt < cnt_w'(clr_start + pulse_cycles)) begin
							e        <= 1'b1;
							lcd_data <= lcd_pkg::cmd_clear;
						end else if (cnt < cnt_w'(em_start)) begin
							e <= 1'b0;
						end else if (cnt < cnt_w'(em_start + pulse_cycles)) begin
							e        <= 1'b1;
							lcd_data <= em_word;
						end else begin
							e <= 1'b0; // wait out the entry mode command
						end
					end
				end
				lcd_pkg::st_ready: begin
					if (lcd_enable) begin
						rs       <= lcd_bus[9];
						rw       <= lcd_bus[8];
						lcd_data <= lcd_bus[7:0];
						busy     <= 1'b1;
						cnt      <= '0;
						state    <= lcd_pkg::st_send;
					end
				end
				lcd_pkg::st_send: begin
					if (cnt == cnt_w'(send_cycles)) begin
						cnt      <= '0;
						e        <= 1'b0;
						rs       <= 1'b0;
						rw       <= 1'b0;
						lcd_data <= 8'h00;
						busy     <= 1'b0;
						state    <= lcd_pkg::st_ready;
					end else begin
						cnt <= cnt_next;
						e   <= (cnt_next >= cnt_w'(e_on)) && (cnt_next < cnt_w'(e_off));
					end
				end
				default: state <= lcd_pkg::st_power_up;
			endcase
		end
	end

endmodule

/* lcd_display_top.sv */
`timescale 1ns/100ps

module lcd_display_top #(
	parameter int clk_freq = 35 // clock cycles per microsecond
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [6:0] cfg,        // lines, font, display, cursor, blink, inc, shift
	input  logic       char_valid,
	input  logic [7:0] char_code,
	output logic       char_ready,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	logic       lcd_enable; // writer to controller request
	logic [9:0] lcd_bus;    // rs, rw, data

	lcd_text_writer u_writer (
		.clk        (clk),
		.rst_n      (rst_n),
		.char_valid (char_valid),
		.char_code  (char_code),
		.char_ready (char_ready),
		.busy       (busy),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus)
	);

	lcd_controller #(
		.clk_freq (clk_freq)
	) u_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.lcd_enable (lcd_enable),
		.lcd_bus    (lcd_bus),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

endmodule

/* lcd_pkg.sv */
package lcd_pkg;

	// controller states
	typedef enum logic [1:0] {
		st_power_up = 2'd0, // waiting after power-up
		st_init     = 2'd1, // fixed command sequence
		st_ready    = 2'd2, // idle, accepts lcd_enable
		st_send     = 2'd3  // one bus transaction
	} ctrl_state_t;

	// HD44780 command opcodes, low bits filled in by the user
	typedef enum logic [7:0] {
		cmd_clear        = 8'h01, // clear display, cursor home
		cmd_entry_mode   = 8'h04, // bit1 increment, bit0 shift
		cmd_display_ctrl = 8'h08, // bit2 display, bit1 cursor, bit0 blink
		cmd_function_set = 8'h30, // 8-bit bus, bit3 lines, bit2 font
		cmd_set_ddram    = 8'h80  // address in bits 6:0
	} lcd_cmd_t;

	// text writer states
	typedef enum logic [1:0] {
		wr_idle = 2'd0, // ready for a character
		wr_addr = 2'd1, // issue set-DDRAM-address
		wr_data = 2'd2, // issue the character
		wr_wait = 2'd3  // wait for the controller
	} wr_state_t;

	// display geometry
	localparam int lcd_cols = 16; // columns per row

	localparam logic [6:0] row1_base = 7'h40; // DDRAM start of second row

endpackage

/* lcd_text_writer.sv */
`timescale 1ns/100ps

module lcd_text_writer (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       char_valid,
	input  logic [7:0] char_code,
	output logic       char_ready,
	input  logic       busy,
	output logic       lcd_enable,
	output logic [9:0] lcd_bus
);

	localparam int col_w = $clog2(lcd_pkg::lcd_cols);

	lcd_pkg::wr_state_t state;
	logic               row;        // 0 top, 1 bottom
	logic [col_w-1:0]   col;
	logic [7:0]         pend_char;  // character waiting to be sent
	logic               addr_sent;  // data still owed after an address
	logic               guard;      // busy not yet valid after a pulse
	logic               accept;
	logic               issue_addr;
	logic               issue_data;
	logic [6:0]         row_addr;
	logic [7:0]         addr_word;

	assign char_ready = (state == lcd_pkg::wr_idle);
	assign accept     = char_valid && char_ready;
	assign issue_addr = (state == lcd_pkg::wr_addr) && !busy;
	assign issue_data = (state == lcd_pkg::wr_data) && !busy;
	assign row_addr   = row ? lcd_pkg::row1_base : 7'h00;
	assign addr_word  = lcd_pkg::cmd_set_ddram | {1'b0, row_addr};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= lcd_pkg::wr_idle;
			row        <= 1'b0;
			col        <= '0;
			addr_sent  <= 1'b0;
			guard      <= 1'b0;
			lcd_enable <= 1'b0;
		end else begin
			lcd_enable <= 1'b0; // single-cycle pulse
			guard      <= 1'b0;
			case (state)
				lcd_pkg::wr_idle: begin
					if (accept)
						state <= (col == '0) ? lcd_pkg::wr_addr : lcd_pkg::wr_data;
				end
				lcd_pkg::wr_addr: begin
					if (issue_addr) begin
						lcd_enable <= 1'b1;
						guard      <= 1'b1;
						addr_sent  <= 1'b1;
						state      <= lcd_pkg::wr_wait;
					end
				end
				lcd_pkg::wr_data: begin
					if (issue_data) begin
						lcd_enable <= 1'b1;
						guard      <= 1'b1;
						addr_sent  <= 1'b0;
						state      <= lcd_pkg::wr_wait;
						if (col == col_w'(lcd_pkg::lcd_cols - 1)) begin
							col <= '0;
							row <= ~row; // wrap to the other row
						end else begin
							col <= col + 1'b1;
						end
					end
				end
				lcd_pkg::wr_wait: begin
					if (!guard && !busy)
						state <= addr_sent ? lcd_pkg::wr_data : lcd_pkg::wr_idle;
				end
				default: state <= lcd_pkg::wr_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pend_char <= char_code;
		if (issue_addr)
			lcd_bus <= {1'b0, 1'b0, addr_word}; // command, write
		else if (issue_data)
			lcd_bus <= {1'b1, 1'b0, pend_char}; // data, write
	end

endmodule

/* list.f */
lcd_pkg.sv
lcd_controller.sv
lcd_text_writer.sv
lcd_display_top.sv
lcd_checker.sv
tb_clock_gen.sv
tb_lcd.sv

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int period = 40 // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

endmodule

/* tb_lcd.sv */
`timescale 1ns/100ps

module tb_lcd;

	localparam int     clk_freq   = 1;  // cycles per microsecond
	localparam int     num_chars  = 40;
	localparam longint timeout_ns = (940 + 42 * 52) * 40 * 2;

	logic       clk;
	logic       rst_n;
	logic [6:0] cfg;
	logic       char_valid;
	logic [7:0] char_code;
	logic       char_ready;
	logic       e;
	logic       rs;
	logic       rw;
	logic [7:0] lcd_data;
	logic       busy;

	integer     seed;
	int         errors;
	int         exp_count;
	int         got_count;
	int         exp_addr;
	int         got_addr;
	int         e_width;    // cycles e has been high
	logic       e_q;
	logic       busy_q;
	logic       init_done;
	logic       char_sent;
	int         cur_col;    // model cursor
	logic       cur_row;
	logic [8:0] exp_q[$];   // rs and data per expected e pulse

	tb_clock_gen #(.period(40)) u_clk (.clk(clk));

	lcd_display_top #(
		.clk_freq (clk_freq)
	) uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.char_valid (char_valid),
		.char_code  (char_code),
		.char_ready (char_ready),
		.e          (e),
		.rs         (rs),
		.rw         (rw),
		.lcd_data   (lcd_data),
		.busy       (busy)
	);

	bind lcd_controller lcd_checker u_chk (
		.clk      (clk),
		.rst_n    (rst_n),
		.e        (e),
		.rs       (rs),
		.lcd_data (lcd_data),
		.busy     (busy),
		.state    (state)
	);

	task automatic expect_word(input logic r, input logic [7:0] d);
		exp_q.push_back({r, d});
		exp_count++;
	endtask

	task automatic send_char(input logic [7:0] code);
		int         r;
		logic [1:0] gap;
		logic [6:0] row_addr;
		while (!char_ready) begin
			@(posedge clk);
			#2;
		end
		r   = $random(seed);
		gap = r[1:0];
		repeat (gap) begin
			@(posedge clk);
			#2;
		end
		// column 0 gets a set-address command first
		if (cur_col == 0) begin
			row_addr = cur_row ? lcd_pkg::row1_base : 7'h00;
			expect_word(1'b0, 8'h80 | {1'b0, row_addr});
			exp_addr++;
		end
		expect_word(1'b1, code);
		if (cur_col == lcd_pkg::lcd_cols - 1) begin
			cur_col = 0;
			cur_row = ~cur_row;
		end else begin
			cur_col++;
		end
		char_valid = 1'b1;
		char_code  = code;
		char_sent  = 1'b1;
		@(posedge clk);
		#2;
		char_valid = 1'b0;
	endtask

	task automatic check_pulse();
		logic [8:0] want;
		string      name;
		int         want_width;
		if (exp_q.size() == 0) begin
			$display("error: e pulse with rs=%0b data=%h came when none was expected",
				rs, lcd_data);
			errors++;
		end else begin
			want = exp_q.pop_front();
			if (got_count < 4)
				name = "init_cmd";
			else if (!want[8])
				name = "cursor_addr";
			else
				name = "char_data";
			want_width = (got_count < 4) ? 10 * clk_freq : 13 * clk_freq;
			if ({rs, lcd_data} != want) begin
				$display("mismatch %s pulse %0d: expected rs=%0b data=%h, actual rs=%0b data=%h",
					name, got_count, want[8], want[7:0], rs, lcd_data);
				errors++;
			end
			if (rw !== 1'b0) begin
				$display("mismatch %s_rw pulse %0d: expected 0, actual %b", name, got_count, rw);
				errors++;
			end
			if (e_width != want_width) begin
				$display("mismatch %s_width pulse %0d: expected %0d, actual %0d",
					name, got_count, want_width, e_width);
				errors++;
			end
		end
		if (got_count >= 4 && !rs)
			got_addr++;
		got_count++;
	endtask

	// bus monitor on the falling clock edge
	always @(negedge clk) begin
		if (!rst_n) begin
			e_q     = 1'b0;
			busy_q  = 1'b1;
			e_width = 0;
		end else begin
			if (e_q && !e) begin
				check_pulse();
				e_width = 0;
			end
			if (e)
				e_width++;
			if (busy_q && !busy && !init_done) begin
				init_done = 1'b1;
				if (got_count != 4) begin
					$display("mismatch init_pulses: expected 4, actual %0d", got_count);
					errors++;
				end
			end
			if (!busy_q && busy && init_done && !char_sent) begin
				$display("error: busy rose again before any character was sent");
				errors++;
			end
			e_q    = e;
			busy_q = busy;
		end
	end

	initial begin
		int r;
		seed       = 32'h6e35;
		errors     = 0;
		exp_count  = 0;
		got_count  = 0;
		exp_addr   = 0;
		got_addr   = 0;
		init_done  = 1'b0;
		char_sent  = 1'b0;
		cur_col    = 0;
		cur_row    = 1'b0;
		rst_n      = 1'b0;
		char_valid = 1'b0;
		char_code  = 8'h00;
		r          = $random(seed);
		cfg        = r[6:0];
		expect_word(1'b0, 8'h30 | {4'b0000, cfg[6:5], 2'b00}); // function set
		expect_word(1'b0, 8'h08 | {5'b00000, cfg[4:2]});       // display control
		expect_word(1'b0, 8'h01);                              // clear
		expect_word(1'b0, 8'h04 | {6'b000000, cfg[1:0]});      // entry mode
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;
		if ({e, busy, char_ready} !== 3'b011) begin
			$display("mismatch reset_state: expected e,busy,char_ready=011, actual %b",
				{e, busy, char_ready});
			errors++;
		end
		while (!init_done) begin
			@(posedge clk);
			#2;
		end
		for (int i = 0; i < num_chars; i++) begin
			r = $random(seed);
			send_char(r[7:0]);
		end
		while (!(char_ready && !busy)) begin
			@(posedge clk);
			#2;
		end
		repeat (4) @(posedge clk);
		if (got_count != exp_count) begin
			$display("mismatch pulse_count: expected %0d, actual %0d", exp_count, got_count);
			errors++;
		end
		if (got_addr != exp_addr) begin
			$display("mismatch addr_count: expected %0d, actual %0d", exp_addr, got_addr);
			errors++;
		end
		errors += uut.u_ctrl.u_chk.fails;
		$display("done: %0d pulses captured, %0d expected, %0d errors",
			got_count, exp_count, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(timeout_ns);
		$display("error: run did not finish within %0d ns", timeout_ns);
		$display("done: %0d pulses captured, %0d expected, %0d errors",
			got_count, exp_count, errors);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
